// File: sources.f
hdl/rv_pkg.sv
hdl/rv_dec_if.sv
hdl/rv_decoder.sv
hdl/rv_regfile.sv
hdl/rv_alu.sv
hdl/rv_lsu.sv
hdl/rv_control.sv
hdl/rv_core.sv
verif/tb_clock.sv
verif/tb_monitor.sv
verif/core_checker.sv
verif/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/tb_core.sv
`timescale 1ns/1ps

module tb_core;
	localparam int ROWS_RUN1 = 64;
	localparam int ROWS_RUN2 = 1;
	localparam int TIMEOUT_CYCLES = 40 * (ROWS_RUN1 + ROWS_RUN2);
	localparam logic [6:0] OPI = 7'h13;
	localparam logic [6:0] LOAD = 7'h03;
	localparam logic [6:0] LUI = 7'h37;
	localparam logic [6:0] AUIPC = 7'h17;
	localparam logic [6:0] JALR = 7'h67;
	localparam rv_pkg::word_t DATA_WORD = 32'h857FF623; // preloaded at 0x100

	logic clk, rstn, restart, check_end, report, trap;
	rv_pkg::word_t axi_araddr, axi_rdata, axi_awaddr, axi_wdata;
	logic axi_arvalid, axi_arready, axi_rvalid, axi_rready;
	logic axi_awvalid, axi_awready, axi_wvalid, axi_wready, axi_bvalid, axi_bready;
	logic [3:0] axi_wstrb;

	rv_pkg::word_t mem [256];
	rv_pkg::word_t row_instr [64];
	logic          row_has [64];
	rv_pkg::word_t row_addr [64];
	logic [3:0]    row_strb [64];
	rv_pkg::word_t row_data [64];
	rv_pkg::word_t exp_addr [32];
	logic [3:0]    exp_strb [32];
	rv_pkg::word_t exp_data [32];
	rv_pkg::word_t trap_pc;
	int            n_rows, exp_count, other_errors, err_total;
	int            cycles = 0;
	integer        seed;
	rv_pkg::word_t rd_addr, wr_addr, wr_data;
	logic [3:0]    wr_strb;
	int            aw_wait, w_wait;
	logic          aw_seen, w_seen;
	rv_pkg::word_t skip;

	tb_clock u_clock (.restart(restart), .clk(clk), .rstn(rstn));

	rv_core DUT (
		.clk(clk), .rstn(rstn),
		.axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
		.axi_rdata(axi_rdata), .axi_rvalid(axi_rvalid), .axi_rready(axi_rready),
		.axi_awaddr(axi_awaddr), .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
		.axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb), .axi_wvalid(axi_wvalid),
		.axi_wready(axi_wready), .axi_bvalid(axi_bvalid), .axi_bready(axi_bready),
		.trap(trap)
	);

	tb_monitor u_monitor (
		.clk(clk), .rstn(rstn), .axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready), .axi_awaddr(axi_awaddr), .axi_awvalid(axi_awvalid),
		.axi_awready(axi_awready), .axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb),
		.axi_wvalid(axi_wvalid), .axi_wready(axi_wready), .axi_bvalid(axi_bvalid),
		.axi_bready(axi_bready), .exp_addr(exp_addr), .exp_strb(exp_strb),
		.exp_data(exp_data), .exp_count(exp_count), .exp_trap_pc(trap_pc),
		.check_end(check_end), .report(report), .other_errors(other_errors),
		.err_total(err_total)
	);

	function automatic rv_pkg::word_t encode_r(input int f7, input int rs2, input int rs1,
		input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic rv_pkg::word_t encode_i(input int imm, input int rs1, input int f3,
		input int rd, input logic [6:0] op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
	endfunction

	function automatic rv_pkg::word_t encode_s(input int imm, input int rs2, input int f3);
		return {imm[11:5], rs2[4:0], 5'd0, f3[2:0], imm[4:0], 7'b0100011}; // base x0
	endfunction

	function automatic rv_pkg::word_t encode_b(input int imm, input int rs2, input int rs1,
		input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic rv_pkg::word_t encode_u(input int imm, input int rd, input logic [6:0] op);
		return {imm[19:0], rd[4:0], op};
	endfunction

	function automatic rv_pkg::word_t encode_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic int rand_delay();
		int r;
		r = $random(seed);
		return r & 3;
	endfunction

	task automatic add_row(input rv_pkg::word_t instr, input logic has,
		input rv_pkg::word_t addr, input logic [3:0] strb, input rv_pkg::word_t data);
		row_instr[n_rows] = instr;
		row_has[n_rows]   = has;
		row_addr[n_rows]  = addr;
		row_strb[n_rows]  = strb;
		row_data[n_rows]  = data;
		n_rows++;
	endtask

	task automatic add_plain(input rv_pkg::word_t instr);
		add_row(instr, 1'b0, '0, '0, '0);
	endtask

	task automatic add_trap(input rv_pkg::word_t instr);
		trap_pc = n_rows * 4; // fetch address of this row
		add_plain(instr);
	endtask

	task automatic build_run1();
		skip = encode_s(32'h2F0, 2, 2); // lands here only on a wrong target
		add_plain(encode_i(-20, 0, 0, 1, OPI));
		add_plain(encode_i(3, 0, 0, 2, OPI));
		add_plain(encode_r(7'h20, 2, 1, 5, 3)); // sra
		add_row(encode_s(32'h200, 3, 2), 1'b1, 32'h200, 4'b1111, 32'hFFFFFFFD);
		add_plain(encode_r(0, 2, 1, 2, 4)); // slt
		add_row(encode_s(32'h204, 4, 2), 1'b1, 32'h204, 4'b1111, 32'h1);
		add_plain(encode_r(0, 2, 1, 3, 5)); // sltu
		add_row(encode_s(32'h208, 5, 2), 1'b1, 32'h208, 4'b1111, 32'h0);
		add_plain(encode_i(5, 0, 0, 0, OPI));
		add_row(encode_s(32'h20C, 0, 2), 1'b1, 32'h20C, 4'b1111, 32'h0);
		add_plain(encode_r(7'h20, 1, 2, 0, 6)); // sub
		add_row(encode_s(32'h210, 6, 2), 1'b1, 32'h210, 4'b1111, 32'h17);
		add_plain(encode_i(32'h0F0, 1, 4, 6, OPI)); // xori
		add_row(encode_s(32'h214, 6, 2), 1'b1, 32'h214, 4'b1111, 32'hFFFFFF1C);
		add_plain(encode_r(0, 2, 2, 1, 6)); // sll
		add_row(encode_s(32'h218, 6, 2), 1'b1, 32'h218, 4'b1111, 32'h18);
		add_plain(encode_i(28, 1, 5, 6, OPI)); // srli
		add_row(encode_s(32'h21C, 6, 2), 1'b1, 32'h21C, 4'b1111, 32'hF);
		add_plain(encode_i(32'h402, 1, 5, 6, OPI)); // srai
		add_row(encode_s(32'h220, 6, 2), 1'b1, 32'h220, 4'b1111, 32'hFFFFFFFB);
		add_plain(encode_r(0, 2, 1, 6, 6)); // or
		add_row(encode_s(32'h224, 6, 2), 1'b1, 32'h224, 4'b1111, 32'hFFFFFFEF);
		add_plain(encode_u(32'h12345, 7, LUI));
		add_row(encode_s(32'h228, 7, 2), 1'b1, 32'h228, 4'b1111, 32'h12345000);
		add_plain(encode_u(32'h1, 7, AUIPC)); // pc 0x60
		add_row(encode_s(32'h22C, 7, 2), 1'b1, 32'h22C, 4'b1111, 32'h1060);
		add_plain(encode_u(32'hA1B2C, 8, LUI));
		add_plain(encode_i(32'h3D4, 8, 0, 8, OPI));
		add_row(encode_s(32'h230, 8, 0), 1'b1, 32'h230, 4'b1000, 32'hD4000000);
		add_row(encode_s(32'h235, 8, 0), 1'b1, 32'h234, 4'b0100, 32'h00D40000);
		add_row(encode_s(32'h23A, 8, 0), 1'b1, 32'h238, 4'b0010, 32'h0000D400);
		add_row(encode_s(32'h23F, 8, 0), 1'b1, 32'h23C, 4'b0001, 32'h000000D4);
		add_row(encode_s(32'h240, 8, 1), 1'b1, 32'h240, 4'b1100, 32'hC3D40000);
		add_row(encode_s(32'h246, 8, 1), 1'b1, 32'h244, 4'b0011, 32'h0000C3D4);
		add_plain(encode_i(32'h100, 0, 0, 9, LOAD)); // lb
		add_row(encode_s(32'h248, 9, 2), 1'b1, 32'h248, 4'b1111, 32'hFFFFFF85);
		add_plain(encode_i(32'h102, 0, 4, 9, LOAD)); // lbu
		add_row(encode_s(32'h24C, 9, 2), 1'b1, 32'h24C, 4'b1111, 32'h000000F6);
		add_plain(encode_i(32'h102, 0, 1, 9, LOAD)); // lh
		add_row(encode_s(32'h250, 9, 2), 1'b1, 32'h250, 4'b1111, 32'hFFFFF623);
		add_plain(encode_i(32'h100, 0, 5, 9, LOAD)); // lhu
		add_row(encode_s(32'h254, 9, 2), 1'b1, 32'h254, 4'b1111, 32'h0000857F);
		add_plain(encode_i(32'h100, 0, 2, 9, LOAD));
		add_row(encode_s(32'h258, 9, 2), 1'b1, 32'h258, 4'b1111, DATA_WORD);
		add_plain(encode_b(8, 2, 2, 0)); // beq taken
		add_plain(skip);
		add_plain(encode_b(8, 2, 2, 1)); // bne falls through
		add_row(encode_s(32'h25C, 2, 2), 1'b1, 32'h25C, 4'b1111, 32'h3);
		add_plain(encode_b(8, 2, 1, 4)); // blt taken
		add_plain(skip);
		add_plain(encode_b(8, 2, 1, 7)); // bgeu taken
		add_plain(skip);
		add_plain(encode_b(8, 2, 1, 6)); // bltu falls through
		add_row(encode_s(32'h260, 1, 2), 1'b1, 32'h260, 4'b1111, 32'hFFFFFFEC);
		add_plain(encode_j(12, 10)); // jal at 0xD8
		add_plain(skip);
		add_plain(skip);
		add_row(encode_s(32'h264, 10, 2), 1'b1, 32'h264, 4'b1111, 32'hDC);
		add_plain(encode_i(249, 0, 0, 11, OPI));
		add_plain(encode_i(0, 11, 0, 12, JALR)); // odd target, lands on 0xF8
		add_plain(skip);
		add_plain(skip);
		add_row(encode_s(32'h268, 12, 2), 1'b1, 32'h268, 4'b1111, 32'hF0);
		add_trap(encode_i(32'h102, 0, 2, 13, LOAD)); // misaligned lw
	endtask

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			mem[i] = {i[7:0], 8'hC3, ~i[7:0], 8'h3C};
		end
		mem[64]   = DATA_WORD;
		exp_count = 0;
		for (int i = 0; i < n_rows; i++) begin
			mem[i] = row_instr[i];
			if (row_has[i]) begin
				exp_addr[exp_count] = row_addr[i];
				exp_strb[exp_count] = row_strb[i];
				exp_data[exp_count] = row_data[i];
				exp_count++;
			end
		end
	endtask

	task automatic store_word(input rv_pkg::word_t addr, input rv_pkg::word_t data,
		input logic [3:0] strb);
		for (int b = 0; b < 4; b++) begin
			if (strb[3-b]) mem[addr[9:2]][31-8*b -: 8] = data[31-8*b -: 8];
		end
	endtask

	task automatic finish_run();
		while (!trap) @(posedge clk);
		repeat (20) @(negedge clk); // bus must stay quiet
		check_end = 1'b1;
		repeat (2) @(negedge clk);
		check_end = 1'b0;
	endtask

	task automatic check_trap_clear();
		@(negedge clk);
		if (trap !== 1'b0) begin
			other_errors++;
			$display("trap was still high after reset at %0t ns", $time);
		end
	endtask

	always begin
		@(negedge clk);
		if (axi_arvalid) begin
			repeat (rand_delay()) @(negedge clk);
			axi_arready = 1'b1;
			rd_addr     = axi_araddr;
			@(negedge clk);
			axi_arready = 1'b0;
			repeat (rand_delay()) @(negedge clk);
			axi_rdata  = mem[rd_addr[9:2]];
			axi_rvalid = 1'b1;
			while (!axi_rready) @(negedge clk); // held until the core takes it
			@(negedge clk);
			axi_rvalid = 1'b0;
		end
	end

	always begin
		@(negedge clk);
		if (axi_awvalid) begin
			wr_addr = axi_awaddr;
			wr_data = axi_wdata;
			wr_strb = axi_wstrb;
			aw_wait = rand_delay();
			w_wait  = rand_delay();
			aw_seen = 1'b0;
			w_seen  = 1'b0;
			while (!(aw_seen && w_seen)) begin
				axi_awready = !aw_seen && aw_wait == 0;
				axi_wready  = !w_seen && w_wait == 0;
				@(negedge clk);
				if (axi_awready) aw_seen = 1'b1;
				if (axi_wready) w_seen = 1'b1;
				if (aw_wait > 0) aw_wait--;
				if (w_wait > 0) w_wait--;
			end
			axi_awready = 1'b0;
			axi_wready  = 1'b0;
			store_word(wr_addr, wr_data, wr_strb);
			repeat (rand_delay()) @(negedge clk);
			axi_bvalid = 1'b1;
			@(negedge clk);
			axi_bvalid = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout: the core did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		axi_arready  = 1'b0;
		axi_rvalid   = 1'b0;
		axi_rdata    = '0;
		axi_awready  = 1'b0;
		axi_wready   = 1'b0;
		axi_bvalid   = 1'b0;
		restart      = 1'b0;
		check_end    = 1'b0;
		report       = 1'b0;
		other_errors = 0;
		seed         = 32'h3ad9;
		n_rows       = 0;
		build_run1();
		load_program();
		@(posedge rstn);
		check_trap_clear();
		finish_run();

		// second run, an all-zero word is illegal
		n_rows = 0;
		add_trap(32'h0);
		load_program();
		restart = 1'b1;
		@(negedge rstn);
		@(posedge rstn);
		restart = 1'b0;
		check_trap_clear();
		finish_run();

		other_errors += DUT.u_checker.fails; // bus assertion failures
		report = 1'b1;
		repeat (2) @(posedge clk);
		if (err_total == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end
endmodule

// File: verif/core_checker.sv
`timescale 1ns/1ps

module core_checker (
	input logic          clk,
	input logic          rstn,
	input logic          axi_arvalid,
	input logic          axi_arready,
	input logic          axi_awvalid,
	input logic          axi_awready,
	input logic          axi_wvalid,
	input logic          axi_wready,
	input rv_pkg::word_t axi_awaddr,
	input rv_pkg::word_t axi_wdata,
	input logic          trap
);
	int fails = 0;

	ar_hold: assert property (@(posedge clk) disable iff (!rstn)
		axi_arvalid && !axi_arready |=> axi_arvalid)
		else begin
			fails++;
			$error("arvalid dropped early");
		end
	aw_hold: assert property (@(posedge clk) disable iff (!rstn)
		axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr))
		else begin
			fails++;
			$error("awvalid or awaddr changed before transfer");
		end
	w_hold: assert property (@(posedge clk) disable iff (!rstn)
		axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata))
		else begin
			fails++;
			$error("wvalid or wdata changed before transfer");
		end
	halt_quiet: assert property (@(posedge clk) disable iff (!rstn)
		trap |-> !axi_arvalid && !axi_awvalid && !axi_wvalid)
		else begin
			fails++;
			$error("bus valid after trap");
		end
endmodule

bind rv_core core_checker u_checker (
	.clk(clk), .rstn(rstn),
	.axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
	.axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
	.axi_wvalid(axi_wvalid), .axi_wready(axi_wready),
	.axi_awaddr(axi_awaddr), .axi_wdata(axi_wdata), .trap(trap)
);

// File: verif/tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor (
	input  logic          clk,
	input  logic          rstn,
	input  rv_pkg::word_t axi_araddr,
	input  logic          axi_arvalid,
	input  logic          axi_arready,
	input  rv_pkg::word_t axi_awaddr,
	input  logic          axi_awvalid,
	input  logic          axi_awready,
	input  rv_pkg::word_t axi_wdata,
	input  logic [3:0]    axi_wstrb,
	input  logic          axi_wvalid,
	input  logic          axi_wready,
	input  logic          axi_bvalid,
	input  logic          axi_bready,
	input  rv_pkg::word_t exp_addr [32],
	input  logic [3:0]    exp_strb [32],
	input  rv_pkg::word_t exp_data [32],
	input  int            exp_count,
	input  rv_pkg::word_t exp_trap_pc,
	input  logic          check_end,
	input  logic          report,
	input  int            other_errors,
	output int            err_total
);
	int            mismatches = 0;
	int            missing = 0;
	int            extra = 0;
	int            wr_idx = 0;
	logic          end_seen = 1'b0;
	logic          reported = 1'b0;
	rv_pkg::word_t last_rd;
	rv_pkg::word_t aw_q;
	rv_pkg::word_t w_q;
	logic [3:0]    s_q;

	assign err_total = mismatches + missing + extra + other_errors;

	always @(posedge clk) begin
		if (!rstn) begin
			wr_idx   = 0; // each run has its own list
			end_seen = 1'b0;
			last_rd  = '1;
		end else begin
			if (axi_arvalid && axi_arready) last_rd = axi_araddr;
			if (axi_awvalid && axi_awready) aw_q = axi_awaddr;
			if (axi_wvalid && axi_wready) begin
				w_q = axi_wdata;
				s_q = axi_wstrb;
			end
			if (axi_bvalid && axi_bready) begin
				if (wr_idx >= exp_count) begin
					extra++;
					$display("Unexpected write to address %h at %0t ns", aw_q, $time);
				end else if (aw_q !== exp_addr[wr_idx] || s_q !== exp_strb[wr_idx] ||
					w_q !== exp_data[wr_idx]) begin
					mismatches++;
					$display("Fail at %0t ns: write %0d got addr %h strb %b data %h, expected %h %b %h",
						$time, wr_idx, aw_q, s_q, w_q,
						exp_addr[wr_idx], exp_strb[wr_idx], exp_data[wr_idx]);
				end
				wr_idx++;
			end
			if (check_end && !end_seen) begin
				end_seen = 1'b1;
				if (last_rd !== exp_trap_pc) begin // trap row is the last fetch
					mismatches++;
					$display("Fail at %0t ns: trap came after a read of %h, expected after %h",
						$time, last_rd, exp_trap_pc);
				end
				if (wr_idx < exp_count) begin
					missing += exp_count - wr_idx;
					$display("%0d expected writes never happened", exp_count - wr_idx);
				end
			end
		end
		if (report && !reported) begin
			reported = 1'b1;
			$display("Errors: %0d mismatched, %0d missing, %0d extra, %0d other",
				mismatches, missing, extra, other_errors);
		end
	end
endmodule

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input  logic restart,
	output logic clk,
	output logic rstn
);
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rstn = 1'b0;
		repeat (2) @(posedge clk); // two rising edges in reset
		@(negedge clk);
		rstn = 1'b1;
		forever begin
			@(posedge restart);
			@(negedge clk);
			rstn = 1'b0;
			repeat (2) @(negedge clk);
			rstn = 1'b1;
		end
	end
endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic          clk,
	input  logic          rstn,
	output rv_pkg::word_t axi_araddr,
	output logic          axi_arvalid,
	input  logic          axi_arready,
	input  rv_pkg::word_t axi_rdata,
	input  logic          axi_rvalid,
	output logic          axi_rready,
	output rv_pkg::word_t axi_awaddr,
	output logic          axi_awvalid,
	input  logic          axi_awready,
	output rv_pkg::word_t axi_wdata,
	output logic [3:0]    axi_wstrb,
	output logic          axi_wvalid,
	input  logic          axi_wready,
	input  logic          axi_bvalid,
	output logic          axi_bready,
	output logic          trap
);
	rv_pkg::word_t    instr;
	rv_pkg::reg_idx_t rd_idx;
	logic             rd_we;
	rv_pkg::word_t    rd_data;
	rv_pkg::word_t    src1;
	rv_pkg::word_t    src2;
	rv_pkg::word_t    alu_result;
	rv_pkg::word_t    mem_addr;
	rv_pkg::word_t    load_data;
	logic [3:0]       wstrb;
	rv_pkg::word_t    wdata;
	logic             misaligned;

	rv_dec_if dec_bus ();

	rv_control u_control (
		.clk(clk), .rstn(rstn),
		.axi_araddr(axi_araddr), .axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
		.axi_rdata(axi_rdata), .axi_rvalid(axi_rvalid), .axi_rready(axi_rready),
		.axi_awaddr(axi_awaddr), .axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
		.axi_wdata(axi_wdata), .axi_wstrb(axi_wstrb), .axi_wvalid(axi_wvalid),
		.axi_wready(axi_wready), .axi_bvalid(axi_bvalid), .axi_bready(axi_bready),
		.trap(trap), .dec(dec_bus.ctl), .instr(instr),
		.rd_idx(rd_idx), .rd_we(rd_we), .rd_data(rd_data),
		.src1(src1), .alu_result(alu_result), .mem_addr(mem_addr),
		.load_data(load_data), .wstrb(wstrb), .wdata(wdata), .misaligned(misaligned)
	);

	rv_decoder u_decoder (.clk(clk), .rstn(rstn), .instr(instr), .dec(dec_bus.dec));

	rv_regfile u_regfile (
		.clk(clk), .rstn(rstn),
		.rd_idx(rd_idx), .rd_we(rd_we), .rd_data(rd_data),
		.rs1_idx(dec_bus.rs1), .rs2_idx(dec_bus.rs2), .src1(src1), .src2(src2)
	);

	rv_alu u_alu (
		.clk(clk), .rstn(rstn), .src1(src1), .src2(src2),
		.dec(dec_bus.alu), .alu_result(alu_result)
	);

	rv_lsu u_lsu (
		.dec(dec_bus.lsu), .addr_low(mem_addr[1:0]), .src2(src2), .rdata(axi_rdata),
		.wstrb(wstrb), .wdata(wdata), .load_data(load_data), .misaligned(misaligned)
	);
endmodule

// File: hdl/rv_control.sv
`timescale 1ns/1ps

module rv_control (
	input  logic             clk,
	input  logic             rstn,
	output rv_pkg::word_t    axi_araddr,
	output logic             axi_arvalid,
	input  logic             axi_arready,
	input  rv_pkg::word_t    axi_rdata,
	input  logic             axi_rvalid,
	output logic             axi_rready,
	output rv_pkg::word_t    axi_awaddr,
	output logic             axi_awvalid,
	input  logic             axi_awready,
	output rv_pkg::word_t    axi_wdata,
	output logic [3:0]       axi_wstrb,
	output logic             axi_wvalid,
	input  logic             axi_wready,
	input  logic             axi_bvalid,
	output logic             axi_bready,
	output logic             trap,
	rv_dec_if.ctl            dec,
	output rv_pkg::word_t    instr,
	output rv_pkg::reg_idx_t rd_idx,
	output logic             rd_we,
	output rv_pkg::word_t    rd_data,
	input  rv_pkg::word_t    src1,
	input  rv_pkg::word_t    alu_result,
	output rv_pkg::word_t    mem_addr,
	input  rv_pkg::word_t    load_data,
	input  logic [3:0]       wstrb,
	input  rv_pkg::word_t    wdata,
	input  logic             misaligned
);
	rv_pkg::ctrl_state_e state;
	logic [1:0]          step;
	rv_pkg::word_t       pc;
	rv_pkg::word_t       load_q;
	rv_pkg::word_t       next_pc;
	logic                aw_done;
	logic                w_done;

	assign mem_addr = src1 + dec.imm;
	assign aw_done  = !axi_awvalid || axi_awready;
	assign w_done   = !axi_wvalid || axi_wready;
	assign rd_idx   = dec.rd;
	assign rd_we    = (state == rv_pkg::st_write) && dec.writes_rd;

	always_comb begin
		case (dec.op_kind)
			rv_pkg::op_lui:   rd_data = dec.imm;
			rv_pkg::op_auipc: rd_data = pc + dec.imm;
			rv_pkg::op_jal,
			rv_pkg::op_jalr:  rd_data = pc + rv_pkg::PC_STEP;
			rv_pkg::op_load:  rd_data = load_q;
			default:          rd_data = alu_result;
		endcase
	end

	always_comb begin
		case (dec.op_kind)
			rv_pkg::op_jal:    next_pc = pc + dec.imm;
			rv_pkg::op_jalr:   next_pc = {mem_addr[31:1], 1'b0};
			rv_pkg::op_branch: next_pc = (alu_result != '0) ? pc + dec.imm : pc + rv_pkg::PC_STEP;
			default:           next_pc = pc + rv_pkg::PC_STEP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state       <= rv_pkg::st_wait;
			step        <= 2'd0;
			pc          <= '0;
			axi_arvalid <= 1'b0;
			axi_rready  <= 1'b0;
			axi_awvalid <= 1'b0;
			axi_wvalid  <= 1'b0;
			axi_bready  <= 1'b0;
			trap        <= 1'b0;
		end else begin
			case (state)
				rv_pkg::st_wait: state <= rv_pkg::st_fetch;
				rv_pkg::st_fetch, rv_pkg::st_mem: begin
					if (state == rv_pkg::st_fetch || dec.op_kind == rv_pkg::op_load) begin
						case (step)
							2'd0: begin
								axi_araddr  <= (state == rv_pkg::st_fetch) ? pc :
									{mem_addr[31:2], 2'b00};
								axi_arvalid <= 1'b1;
								step        <= 2'd1;
							end
							2'd1: begin
								if (axi_arready) begin
									axi_arvalid <= 1'b0;
									axi_rready  <= 1'b1;
									step        <= 2'd2;
								end
							end
							default: begin
								if (axi_rvalid) begin
									axi_rready <= 1'b0;
									step       <= 2'd0;
									if (state == rv_pkg::st_fetch) begin
										instr <= axi_rdata;
										state <= rv_pkg::st_decode;
									end else begin
										load_q <= load_data; // lane already extracted
										state  <= rv_pkg::st_write;
									end
								end
							end
						endcase
					end else if (dec.op_kind == rv_pkg::op_store) begin
						case (step)
							2'd0: begin
								axi_awaddr  <= {mem_addr[31:2], 2'b00};
								axi_wdata   <= wdata;
								axi_wstrb   <= wstrb;
								axi_awvalid <= 1'b1;
								axi_wvalid  <= 1'b1;
								step        <= 2'd1;
							end
							2'd1: begin
								if (axi_awready) begin
									axi_awvalid <= 1'b0;
								end
								if (axi_wready) begin
									axi_wvalid <= 1'b0;
								end
								if (aw_done && w_done) begin // both channels done
									axi_bready <= 1'b1;
									step       <= 2'd2;
								end
							end
							default: begin
								if (axi_bvalid) begin
									axi_bready <= 1'b0;
									step       <= 2'd0;
									state      <= rv_pkg::st_write;
								end
							end
						endcase
					end else begin
						state <= rv_pkg::st_write;
					end
				end
				rv_pkg::st_decode: state <= rv_pkg::st_exec;
				rv_pkg::st_exec: begin
					if (dec.illegal || misaligned) begin
						trap  <= 1'b1;
						state <= rv_pkg::st_halt;
					end else begin
						state <= rv_pkg::st_mem;
					end
				end
				rv_pkg::st_write: begin
					pc    <= next_pc;
					step  <= 2'd0;
					state <= rv_pkg::st_fetch;
				end
				default: state <= rv_pkg::st_halt; // stays until reset
			endcase
		end
	end
endmodule

// File: hdl/rv_lsu.sv
`timescale 1ns/1ps

module rv_lsu (
	rv_dec_if.lsu         dec,
	input  logic [1:0]    addr_low,
	input  rv_pkg::word_t src2,
	input  rv_pkg::word_t rdata,
	output logic [3:0]    wstrb,
	output rv_pkg::word_t wdata,
	output rv_pkg::word_t load_data,
	output logic          misaligned
);
	logic [4:0]    lane_shift;
	rv_pkg::word_t lane_rdata;

	assign lane_shift = {addr_low, 3'b000};
	assign lane_rdata = rdata << lane_shift; // selected lane ends up on top

	// byte 0 sits in bits 31:24
	always_comb begin
		case (dec.mem_op)
			rv_pkg::mem_sb: begin
				wstrb = 4'b1000 >> addr_low;
				wdata = {src2[7:0], 24'd0} >> lane_shift;
			end
			rv_pkg::mem_sh: begin
				wstrb = 4'b1100 >> addr_low;
				wdata = {src2[15:0], 16'd0} >> lane_shift;
			end
			rv_pkg::mem_sw: begin
				wstrb = 4'b1111;
				wdata = src2;
			end
			default: begin
				wstrb = 4'b0000;
				wdata = '0;
			end
		endcase
	end

	always_comb begin
		case (dec.mem_op)
			rv_pkg::mem_lb:  load_data = {{24{lane_rdata[31]}}, lane_rdata[31:24]};
			rv_pkg::mem_lbu: load_data = {24'd0, lane_rdata[31:24]};
			rv_pkg::mem_lh:  load_data = {{16{lane_rdata[31]}}, lane_rdata[31:16]};
			rv_pkg::mem_lhu: load_data = {16'd0, lane_rdata[31:16]};
			default:         load_data = rdata;
		endcase
	end

	always_comb begin
		case (dec.mem_op)
			rv_pkg::mem_lh, rv_pkg::mem_lhu, rv_pkg::mem_sh: misaligned = addr_low[0];
			rv_pkg::mem_lw, rv_pkg::mem_sw:                  misaligned = addr_low != 2'b00;
			default:                                         misaligned = 1'b0;
		endcase
	end
endmodule

// File: hdl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
	input  logic          clk,
	input  logic          rstn,
	input  rv_pkg::word_t src1,
	input  rv_pkg::word_t src2,
	rv_dec_if.alu         dec,
	output rv_pkg::word_t alu_result
);
	rv_pkg::word_t opb;
	logic [4:0]    shamt;
	rv_pkg::word_t res_n;

	assign opb   = dec.use_imm ? dec.imm : src2;
	assign shamt = opb[4:0];

	always_comb begin
		case (dec.alu_op)
			rv_pkg::alu_add:  res_n = src1 + opb;
			rv_pkg::alu_sub:  res_n = src1 - opb;
			rv_pkg::alu_slt,
			rv_pkg::alu_lt:   res_n = rv_pkg::word_t'($signed(src1) < $signed(opb));
			rv_pkg::alu_sltu,
			rv_pkg::alu_ltu:  res_n = rv_pkg::word_t'(src1 < opb);
			rv_pkg::alu_xor:  res_n = src1 ^ opb;
			rv_pkg::alu_or:   res_n = src1 | opb;
			rv_pkg::alu_and:  res_n = src1 & opb;
			rv_pkg::alu_sll:  res_n = src1 << shamt;
			rv_pkg::alu_srl:  res_n = src1 >> shamt;
			rv_pkg::alu_sra:  res_n = $signed(src1) >>> shamt;
			rv_pkg::alu_eq:   res_n = rv_pkg::word_t'(src1 == opb);
			rv_pkg::alu_ne:   res_n = rv_pkg::word_t'(src1 != opb);
			rv_pkg::alu_ge:   res_n = rv_pkg::word_t'($signed(src1) >= $signed(opb));
			rv_pkg::alu_geu:  res_n = rv_pkg::word_t'(src1 >= opb);
			default:          res_n = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			alu_result <= '0;
		end else begin
			alu_result <= res_n;
		end
	end
endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
	input  logic             clk,
	input  logic             rstn,
	input  rv_pkg::reg_idx_t rd_idx,
	input  logic             rd_we,
	input  rv_pkg::word_t    rd_data,
	input  rv_pkg::reg_idx_t rs1_idx,
	input  rv_pkg::reg_idx_t rs2_idx,
	output rv_pkg::word_t    src1,
	output rv_pkg::word_t    src2
);
	rv_pkg::word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (rd_we && rd_idx != '0) begin
			regs[rd_idx] <= rd_data;
		end
	end

	assign src1 = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign src2 = (rs2_idx == '0) ? '0 : regs[rs2_idx];
endmodule

// File: hdl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
	input  logic          clk,
	input  logic          rstn,
	input  rv_pkg::word_t instr,
	rv_dec_if.dec         dec
);
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic            is_reg;
	rv_pkg::word_t   i_imm;
	rv_pkg::alu_op_e arith_op;
	logic            arith_ok;
	rv_pkg::opcode_e op_n;
	rv_pkg::alu_op_e alu_n;
	rv_pkg::mem_op_e mem_n;
	rv_pkg::word_t   imm_n;
	logic            use_imm_n;
	logic            writes_n;
	logic            illegal_n;

	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign is_reg = instr[5]; // op vs op-imm
	assign i_imm  = {{20{instr[31]}}, instr[31:20]};

	// shared by register and immediate forms
	always_comb begin
		case (funct3)
			3'b000: arith_op = (is_reg && funct7[5]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001: arith_op = rv_pkg::alu_sll;
			3'b010: arith_op = rv_pkg::alu_slt;
			3'b011: arith_op = rv_pkg::alu_sltu;
			3'b100: arith_op = rv_pkg::alu_xor;
			3'b101: arith_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110: arith_op = rv_pkg::alu_or;
			default: arith_op = rv_pkg::alu_and;
		endcase
		if (is_reg || funct3[1:0] == 2'b01) begin // funct7 is imm bits otherwise
			arith_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000 &&
				(funct3 == 3'b101 || (funct3 == 3'b000 && is_reg)));
		end else begin
			arith_ok = 1'b1;
		end
	end

	always_comb begin
		op_n      = rv_pkg::op_reg;
		alu_n     = rv_pkg::alu_add;
		mem_n     = rv_pkg::mem_none;
		imm_n     = '0;
		use_imm_n = 1'b0;
		writes_n  = 1'b0;
		illegal_n = 1'b0;
		case (instr[6:0])
			rv_pkg::op_lui: begin
				op_n     = rv_pkg::op_lui;
				imm_n    = {instr[31:12], 12'd0};
				writes_n = 1'b1;
			end
			rv_pkg::op_auipc: begin
				op_n     = rv_pkg::op_auipc;
				imm_n    = {instr[31:12], 12'd0};
				writes_n = 1'b1;
			end
			rv_pkg::op_jal: begin
				op_n     = rv_pkg::op_jal;
				imm_n    = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
				writes_n = 1'b1;
			end
			rv_pkg::op_jalr: begin
				op_n      = rv_pkg::op_jalr;
				imm_n     = i_imm;
				writes_n  = 1'b1;
				illegal_n = funct3 != 3'b000;
			end
			rv_pkg::op_branch: begin
				op_n  = rv_pkg::op_branch;
				imm_n = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
				case (funct3)
					3'b000: alu_n = rv_pkg::alu_eq;
					3'b001: alu_n = rv_pkg::alu_ne;
					3'b100: alu_n = rv_pkg::alu_lt;
					3'b101: alu_n = rv_pkg::alu_ge;
					3'b110: alu_n = rv_pkg::alu_ltu;
					3'b111: alu_n = rv_pkg::alu_geu;
					default: illegal_n = 1'b1;
				endcase
			end
			rv_pkg::op_load: begin
				op_n     = rv_pkg::op_load;
				imm_n    = i_imm;
				writes_n = 1'b1;
				case (funct3)
					3'b000: mem_n = rv_pkg::mem_lb;
					3'b001: mem_n = rv_pkg::mem_lh;
					3'b010: mem_n = rv_pkg::mem_lw;
					3'b100: mem_n = rv_pkg::mem_lbu;
					3'b101: mem_n = rv_pkg::mem_lhu;
					default: illegal_n = 1'b1;
				endcase
			end
			rv_pkg::op_store: begin
				op_n  = rv_pkg::op_store;
				imm_n = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				case (funct3)
					3'b000: mem_n = rv_pkg::mem_sb;
					3'b001: mem_n = rv_pkg::mem_sh;
					3'b010: mem_n = rv_pkg::mem_sw;
					default: illegal_n = 1'b1;
				endcase
			end
			rv_pkg::op_imm: begin
				op_n      = rv_pkg::op_imm;
				imm_n     = i_imm;
				use_imm_n = 1'b1;
				writes_n  = 1'b1;
				alu_n     = arith_op;
				illegal_n = !arith_ok;
			end
			rv_pkg::op_reg: begin
				writes_n  = 1'b1;
				alu_n     = arith_op;
				illegal_n = !arith_ok;
			end
			default: illegal_n = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			dec.op_kind   <= rv_pkg::op_reg;
			dec.alu_op    <= rv_pkg::alu_add;
			dec.mem_op    <= rv_pkg::mem_none;
			dec.use_imm   <= 1'b0;
			dec.writes_rd <= 1'b0;
			dec.illegal   <= 1'b0;
		end else begin
			dec.op_kind   <= op_n;
			dec.alu_op    <= alu_n;
			dec.mem_op    <= mem_n;
			dec.use_imm   <= use_imm_n;
			dec.writes_rd <= writes_n;
			dec.illegal   <= illegal_n;
		end
	end

	always_ff @(posedge clk) begin
		dec.rd  <= instr[11:7];
		dec.rs1 <= instr[19:15];
		dec.rs2 <= instr[24:20];
		dec.imm <= imm_n;
	end
endmodule

// File: hdl/rv_dec_if.sv
`timescale 1ns/1ps

interface rv_dec_if;
	rv_pkg::opcode_e  op_kind;
	rv_pkg::alu_op_e  alu_op;
	rv_pkg::mem_op_e  mem_op;
	rv_pkg::reg_idx_t rd;
	rv_pkg::reg_idx_t rs1;
	rv_pkg::reg_idx_t rs2;
	rv_pkg::word_t    imm;
	logic             use_imm;
	logic             writes_rd;
	logic             illegal;

	modport dec (output op_kind, alu_op, mem_op, rd, rs1, rs2, imm, use_imm, writes_rd, illegal);
	modport ctl (input op_kind, rd, imm, writes_rd, illegal);
	modport alu (input alu_op, imm, use_imm);
	modport lsu (input mem_op);
endinterface

// File: hdl/rv_pkg.sv
package rv_pkg;

	localparam int XLEN    = 32;
	localparam int REG_AW  = 5;
	localparam int PC_STEP = 4;

	typedef logic [XLEN-1:0]   word_t;
	typedef logic [REG_AW-1:0] reg_idx_t;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_slt, alu_sltu,
		alu_xor, alu_or, alu_and,
		alu_sll, alu_srl, alu_sra,
		alu_eq, alu_ne, alu_lt, alu_ge, alu_ltu, alu_geu
	} alu_op_e;

	typedef enum logic [3:0] {
		mem_none,
		mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
		mem_sb, mem_sh, mem_sw
	} mem_op_e;

	typedef enum logic [2:0] {
		st_wait,
		st_fetch,
		st_decode,
		st_exec,
		st_mem,
		st_write,
		st_halt
	} ctrl_state_e;

endpackage
